// ==== Makefile ====
TOP = tsp_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f $(wildcard hw/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "^RESULT: PASS$$" sim.log

lint:
	verilator --lint-only --timing -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
hw/tsp_pkg.sv
hw/ts_frame_fsm.sv
hw/ts_byte_counter.sv
hw/tsp_regs.sv
hw/ts_capture_buf.sv
hw/ts_replacer.sv
hw/tsp_top.sv
tb/tsp_tb.sv

// ==== hw/ts_byte_counter.sv ====
`timescale 1ns/10ps

module ts_byte_counter (
	input logic mpeg_clk,
	input logic rst_n,
	input logic cnt_clear,
	input logic cnt_inc,
	output tsp_pkg::byte_idx_t byte_idx,
	output logic last_byte
);

	tsp_pkg::byte_idx_t cnt_q;

	// byte_idx is the position of the byte on the input in this cycle.
	// A sync byte is position 0 whatever the count was.
	assign byte_idx = cnt_clear ? '0 : cnt_q;
	assign last_byte = (byte_idx == tsp_pkg::byte_idx_t'(tsp_pkg::PKT_BYTES - 1));

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (cnt_inc) begin
			cnt_q <= last_byte ? '0 : byte_idx + 8'd1;
		end else if (cnt_clear) begin
			cnt_q <= '0;
		end
	end

	assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		byte_idx < tsp_pkg::byte_idx_t'(tsp_pkg::PKT_BYTES))
		else $error("byte index ran past the end of a packet");

endmodule

// ==== hw/ts_capture_buf.sv ====
`timescale 1ns/10ps

module ts_capture_buf (
	input logic mpeg_clk,
	input logic rst_n,
	input tsp_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input tsp_pkg::byte_idx_t byte_idx,
	input logic pkt_start,
	input tsp_pkg::pid_t pid,
	input logic pid_valid,
	input tsp_pkg::pid_t mon_pid,
	input logic mon_en,
	input logic cap_arm,
	input tsp_pkg::word_idx_t cap_raddr,
	output tsp_pkg::reg_data_t cap_rdata,
	output logic cap_ready
);

	tsp_pkg::reg_data_t mem [0:tsp_pkg::PKT_WORDS-1];
	tsp_pkg::ts_byte_t lane_q [0:2];
	logic armed;
	logic collecting;
	logic [1:0] lane;
	logic last_in;

	assign lane = byte_idx[1:0];
	assign last_in = collecting && mpeg_valid &&
		(byte_idx == tsp_pkg::byte_idx_t'(tsp_pkg::PKT_BYTES - 1));

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			armed <= 1'b0;
			collecting <= 1'b0;
			cap_ready <= 1'b0;
		end else if (cap_arm) begin
			armed <= 1'b1;
			collecting <= 1'b0;
			cap_ready <= 1'b0;
		end else if (last_in) begin
			armed <= 1'b0;
			collecting <= 1'b0;
			cap_ready <= 1'b1;
		end else if (pkt_start) begin
			// a new packet throws away whatever was partly collected.
			collecting <= armed;
		end else if (pid_valid && collecting) begin
			collecting <= mon_en && (pid == mon_pid);
		end
	end

	// bytes are little-endian inside a word, byte 0 in bits 7..0.
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid && (lane != 2'd3)) begin
			lane_q[lane] <= mpeg_data;
		end
		if (mpeg_valid && collecting && (lane == 2'd3)) begin
			mem[byte_idx[7:2]] <= {mpeg_data, lane_q[2], lane_q[1], lane_q[0]};
		end
	end

	assign cap_rdata = mem[cap_raddr];

endmodule

// ==== hw/ts_frame_fsm.sv ====
`timescale 1ns/10ps

module ts_frame_fsm (
	input logic mpeg_clk,
	input logic rst_n,
	input tsp_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input tsp_pkg::byte_idx_t byte_idx,
	input logic last_byte,
	output logic cnt_clear,
	output logic cnt_inc,
	output logic pkt_start,
	output tsp_pkg::pid_t pid,
	output logic pid_valid
);

	tsp_pkg::frame_state_t state;
	logic start;
	logic [4:0] pid_hi;
	logic pid_seen;

	// a sync byte restarts framing from any state, even mid-packet.
	assign start = mpeg_valid && mpeg_sync && (mpeg_data == tsp_pkg::SYNC_BYTE);
	assign cnt_clear = start;
	assign cnt_inc = start || (mpeg_valid && (state != tsp_pkg::ST_HUNT));

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			state <= tsp_pkg::ST_HUNT;
			pkt_start <= 1'b0;
			pid_valid <= 1'b0;
		end else begin
			pkt_start <= start;
			pid_valid <= 1'b0;
			if (start) begin
				state <= tsp_pkg::ST_HEADER;
			end else if (mpeg_valid) begin
				case (state)
					tsp_pkg::ST_HEADER: begin
						if (byte_idx == 8'd2) begin
							state <= tsp_pkg::ST_BODY;
							pid_valid <= 1'b1;
						end
					end
					tsp_pkg::ST_BODY: begin
						if (last_byte) begin
							state <= tsp_pkg::ST_HUNT;
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	// PID sits in the low five bits of byte 1 and all of byte 2.
	always_ff @(posedge mpeg_clk) begin
		if (mpeg_valid && (state == tsp_pkg::ST_HEADER)) begin
			if (byte_idx == 8'd1) begin
				pid_hi <= mpeg_data[4:0];
			end
			if (byte_idx == 8'd2) begin
				pid <= {pid_hi, mpeg_data};
			end
		end
	end

	// remembers that the current packet already produced its PID.
	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			pid_seen <= 1'b0;
		end else if (pkt_start) begin
			pid_seen <= 1'b0;
		end else if (pid_valid) begin
			pid_seen <= 1'b1;
		end
	end

	assert property (@(posedge mpeg_clk) disable iff (!rst_n)
		pid_valid |-> !pid_seen)
		else $error("pid_valid fired twice within one packet");

endmodule

// ==== hw/ts_replacer.sv ====
`timescale 1ns/10ps

module ts_replacer (
	input logic mpeg_clk,
	input logic rst_n,
	input tsp_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input tsp_pkg::pid_t pid,
	input logic pid_valid,
	input tsp_pkg::pid_t rep_pid,
	input logic rep_en,
	input logic rep_wr,
	input tsp_pkg::word_idx_t rep_word_addr,
	input tsp_pkg::reg_data_t rep_wdata,
	output tsp_pkg::ts_byte_t ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);

	tsp_pkg::reg_data_t rep_mem [0:tsp_pkg::PKT_WORDS-1];
	tsp_pkg::ts_byte_t dly [0:2];
	logic [2:0] dly_v;
	logic [2:0] dly_sync;
	logic [2:0] dly_start;
	tsp_pkg::byte_idx_t out_idx;
	tsp_pkg::byte_idx_t cur_idx;
	logic out_in_pkt;
	logic cur_in_pkt;
	logic start_in;
	logic rep_q;
	logic rep_act;
	tsp_pkg::reg_data_t rep_word;

	assign start_in = mpeg_sync && (mpeg_data == tsp_pkg::SYNC_BYTE);

	// position of the byte leaving the delay line.
	assign cur_idx = dly_start[2] ? '0 : out_idx;
	assign cur_in_pkt = dly_start[2] || out_in_pkt;

	// byte 0 may leave in the very cycle the decision is made.
	assign rep_act = pid_valid ? (rep_en && (pid == rep_pid)) : rep_q;
	assign rep_word = rep_mem[cur_idx[7:2]];

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			dly_v <= '0;
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
			out_idx <= '0;
			out_in_pkt <= 1'b0;
			rep_q <= 1'b0;
		end else begin
			ts_out_valid <= mpeg_valid && dly_v[2];
			ts_out_sync <= mpeg_valid && dly_v[2] && dly_sync[2];
			if (pid_valid) begin
				rep_q <= rep_en && (pid == rep_pid);
			end
			if (mpeg_valid) begin
				dly_v <= {dly_v[1:0], 1'b1};
				if (dly_v[2]) begin
					out_in_pkt <= cur_in_pkt &&
						(cur_idx != tsp_pkg::byte_idx_t'(tsp_pkg::PKT_BYTES - 1));
					out_idx <= (cur_in_pkt &&
						(cur_idx != tsp_pkg::byte_idx_t'(tsp_pkg::PKT_BYTES - 1))) ?
						cur_idx + 8'd1 : '0;
				end
			end
		end
	end

	always_ff @(posedge mpeg_clk) begin
		if (rep_wr) begin
			rep_mem[rep_word_addr] <= rep_wdata;
		end
		if (mpeg_valid) begin
			dly[0] <= mpeg_data;
			dly[1] <= dly[0];
			dly[2] <= dly[1];
			dly_sync <= {dly_sync[1:0], mpeg_sync};
			dly_start <= {dly_start[1:0], start_in};
			if (cur_in_pkt && rep_act) begin
				ts_out <= rep_word[{cur_idx[1:0], 3'b000} +: 8];
			end else begin
				ts_out <= dly[2];
			end
		end
	end

endmodule

// ==== hw/tsp_pkg.sv ====
package tsp_pkg;

	typedef logic [7:0] ts_byte_t;
	typedef logic [12:0] pid_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [7:0] byte_idx_t;
	typedef logic [5:0] word_idx_t;

	typedef enum logic [1:0] {
		ST_HUNT,
		ST_HEADER,
		ST_BODY
	} frame_state_t;

	localparam int PKT_BYTES = 188;
	localparam int PKT_WORDS = 47;
	localparam ts_byte_t SYNC_BYTE = 8'h47;

	// PID registers carry the enable in bit 16 and the PID in bits 12..0.
	localparam reg_addr_t ADDR_MON_PID = 8'd0;
	localparam reg_addr_t ADDR_REP_PID = 8'd1;
	localparam reg_addr_t ADDR_CAP_ARM = 8'd2;
	localparam reg_addr_t ADDR_STATUS = 8'd3;

	// reads here return captured words, writes fill the replacement packet.
	localparam reg_addr_t ADDR_PKT_BASE = 8'd64;

endpackage

// ==== hw/tsp_regs.sv ====
`timescale 1ns/10ps

module tsp_regs (
	input logic mpeg_clk,
	input logic rst_n,
	input logic wen,
	input tsp_pkg::reg_addr_t waddr,
	input tsp_pkg::reg_data_t wdata,
	input logic ren,
	input tsp_pkg::reg_addr_t raddr,
	input tsp_pkg::reg_data_t cap_rdata,
	input logic cap_ready,
	output tsp_pkg::reg_data_t rdata,
	output tsp_pkg::pid_t mon_pid,
	output logic mon_en,
	output tsp_pkg::pid_t rep_pid,
	output logic rep_en,
	output logic cap_arm,
	output tsp_pkg::word_idx_t cap_raddr,
	output logic rep_wr,
	output tsp_pkg::word_idx_t rep_word_addr,
	output tsp_pkg::reg_data_t rep_wdata
);

	logic wr_pkt;
	logic rd_pkt;

	assign wr_pkt = wen && (waddr >= tsp_pkg::ADDR_PKT_BASE) &&
		(waddr < tsp_pkg::ADDR_PKT_BASE + tsp_pkg::reg_addr_t'(tsp_pkg::PKT_WORDS));
	assign rd_pkt = (raddr >= tsp_pkg::ADDR_PKT_BASE) &&
		(raddr < tsp_pkg::ADDR_PKT_BASE + tsp_pkg::reg_addr_t'(tsp_pkg::PKT_WORDS));
	assign cap_raddr = tsp_pkg::word_idx_t'(raddr - tsp_pkg::ADDR_PKT_BASE);

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			mon_pid <= '0;
			mon_en <= 1'b0;
			rep_pid <= '0;
			rep_en <= 1'b0;
			cap_arm <= 1'b0;
			rep_wr <= 1'b0;
		end else begin
			cap_arm <= wen && (waddr == tsp_pkg::ADDR_CAP_ARM);
			rep_wr <= wr_pkt;
			if (wen && (waddr == tsp_pkg::ADDR_MON_PID)) begin
				mon_en <= wdata[16];
				mon_pid <= wdata[12:0];
			end
			if (wen && (waddr == tsp_pkg::ADDR_REP_PID)) begin
				rep_en <= wdata[16];
				rep_pid <= wdata[12:0];
			end
		end
	end

	// the replacement write lands in the replacer one cycle after wen.
	always_ff @(posedge mpeg_clk) begin
		rep_word_addr <= tsp_pkg::word_idx_t'(waddr - tsp_pkg::ADDR_PKT_BASE);
		rep_wdata <= wdata;
	end

	always_ff @(posedge mpeg_clk) begin
		if (!rst_n) begin
			rdata <= '0;
		end else if (ren) begin
			if (rd_pkt) begin
				rdata <= cap_rdata;
			end else begin
				case (raddr)
					tsp_pkg::ADDR_MON_PID: rdata <= {15'd0, mon_en, 3'd0, mon_pid};
					tsp_pkg::ADDR_REP_PID: rdata <= {15'd0, rep_en, 3'd0, rep_pid};
					tsp_pkg::ADDR_STATUS: rdata <= {31'd0, cap_ready};
					default: rdata <= '0;
				endcase
			end
		end
	end

	assert property (@(posedge mpeg_clk) disable iff (!rst_n) !(wen && ren))
		else $error("register write and read requested in the same cycle");

endmodule

// ==== hw/tsp_top.sv ====
`timescale 1ns/10ps

module tsp_top (
	input logic mpeg_clk,
	input logic rst_n,
	input tsp_pkg::ts_byte_t mpeg_data,
	input logic mpeg_valid,
	input logic mpeg_sync,
	input logic wen,
	input tsp_pkg::reg_addr_t waddr,
	input tsp_pkg::reg_data_t wdata,
	input logic ren,
	input tsp_pkg::reg_addr_t raddr,
	output tsp_pkg::reg_data_t rdata,
	output tsp_pkg::ts_byte_t ts_out,
	output logic ts_out_valid,
	output logic ts_out_sync
);

	logic cnt_clear;
	logic cnt_inc;
	logic last_byte;
	logic pkt_start;
	logic pid_valid;
	logic mon_en;
	logic rep_en;
	logic cap_arm;
	logic cap_ready;
	logic rep_wr;
	tsp_pkg::byte_idx_t byte_idx;
	tsp_pkg::pid_t pid;
	tsp_pkg::pid_t mon_pid;
	tsp_pkg::pid_t rep_pid;
	tsp_pkg::word_idx_t cap_raddr;
	tsp_pkg::word_idx_t rep_word_addr;
	tsp_pkg::reg_data_t cap_rdata;
	tsp_pkg::reg_data_t rep_wdata;

	ts_frame_fsm frame_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.byte_idx(byte_idx),
		.last_byte(last_byte),
		.cnt_clear(cnt_clear),
		.cnt_inc(cnt_inc),
		.pkt_start(pkt_start),
		.pid(pid),
		.pid_valid(pid_valid)
	);

	ts_byte_counter counter_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.cnt_clear(cnt_clear),
		.cnt_inc(cnt_inc),
		.byte_idx(byte_idx),
		.last_byte(last_byte)
	);

	tsp_regs regs_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.cap_rdata(cap_rdata),
		.cap_ready(cap_ready),
		.rdata(rdata),
		.mon_pid(mon_pid),
		.mon_en(mon_en),
		.rep_pid(rep_pid),
		.rep_en(rep_en),
		.cap_arm(cap_arm),
		.cap_raddr(cap_raddr),
		.rep_wr(rep_wr),
		.rep_word_addr(rep_word_addr),
		.rep_wdata(rep_wdata)
	);

	ts_capture_buf capture_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.byte_idx(byte_idx),
		.pkt_start(pkt_start),
		.pid(pid),
		.pid_valid(pid_valid),
		.mon_pid(mon_pid),
		.mon_en(mon_en),
		.cap_arm(cap_arm),
		.cap_raddr(cap_raddr),
		.cap_rdata(cap_rdata),
		.cap_ready(cap_ready)
	);

	ts_replacer replacer_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.pid(pid),
		.pid_valid(pid_valid),
		.rep_pid(rep_pid),
		.rep_en(rep_en),
		.rep_wr(rep_wr),
		.rep_word_addr(rep_word_addr),
		.rep_wdata(rep_wdata),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync)
	);

endmodule

// ==== tb/tsp_tb.sv ====
`timescale 1ns/10ps

module tsp_tb;

	logic mpeg_clk;
	logic rst_n;
	tsp_pkg::ts_byte_t mpeg_data;
	logic mpeg_valid;
	logic mpeg_sync;
	logic wen;
	tsp_pkg::reg_addr_t waddr;
	tsp_pkg::reg_data_t wdata;
	logic ren;
	tsp_pkg::reg_addr_t raddr;
	tsp_pkg::reg_data_t rdata;
	tsp_pkg::ts_byte_t ts_out;
	logic ts_out_valid;
	logic ts_out_sync;

	// one entry per accepted input byte, in stream order.
	tsp_pkg::ts_byte_t hist_data[$];
	logic hist_sync[$];
	logic hist_rep[$];
	int hist_pos[$];
	tsp_pkg::reg_data_t cap_q[$];
	tsp_pkg::ts_byte_t rep_pkt [0:tsp_pkg::PKT_BYTES-1];
	tsp_pkg::pid_t pid_list [0:2];
	tsp_pkg::pid_t mon_pid_m;
	tsp_pkg::pid_t rep_pid_m;
	logic mon_en_m;
	logic rep_en_m;
	logic cap_pending;
	int out_cnt;
	int in_cnt;
	logic in_prev;

	tsp_top dut_i (
		.mpeg_clk(mpeg_clk),
		.rst_n(rst_n),
		.mpeg_data(mpeg_data),
		.mpeg_valid(mpeg_valid),
		.mpeg_sync(mpeg_sync),
		.wen(wen),
		.waddr(waddr),
		.wdata(wdata),
		.ren(ren),
		.raddr(raddr),
		.rdata(rdata),
		.ts_out(ts_out),
		.ts_out_valid(ts_out_valid),
		.ts_out_sync(ts_out_sync)
	);

	always #2 mpeg_clk = ~mpeg_clk;

	task fail_now(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task check_byte(input string name, input tsp_pkg::ts_byte_t got, input tsp_pkg::ts_byte_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task check_word(input string name, input tsp_pkg::reg_data_t got,
		input tsp_pkg::reg_data_t exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			fail_now($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// a byte of a replaced packet comes from the stored packet at the same position.
	function automatic tsp_pkg::ts_byte_t exp_byte(input int k);
		if (hist_rep[k]) begin
			return rep_pkt[hist_pos[k]];
		end
		return hist_data[k];
	endfunction

	function automatic tsp_pkg::reg_data_t pid_word(input logic en, input tsp_pkg::pid_t p);
		tsp_pkg::reg_data_t w;
		w = '0;
		w[16] = en;
		w[12:0] = p;
		return w;
	endfunction

	always @(negedge mpeg_clk) begin
		if (rst_n) begin
			// byte k leaves in the cycle after input byte k+3 was taken.
			check_flag("ts_out_valid", ts_out_valid, in_prev && (in_cnt >= 4));
		end
		if (rst_n && ts_out_valid) begin
			if (out_cnt >= hist_data.size()) begin
				fail_now("an output byte appeared with no input byte behind it");
			end
			check_byte("ts_out", ts_out, exp_byte(out_cnt));
			check_flag("ts_out_sync", ts_out_sync, hist_sync[out_cnt]);
			out_cnt++;
		end else if (rst_n) begin
			check_flag("ts_out_sync", ts_out_sync, 1'b0);
		end
		in_prev = rst_n && mpeg_valid;
		if (rst_n && mpeg_valid) begin
			in_cnt++;
		end
	end

	task push_byte(input tsp_pkg::ts_byte_t b, input logic s, input logic rep, input int pos);
		int gap;
		gap = $urandom_range(2, 0);
		repeat (gap) begin
			@(posedge mpeg_clk);
			mpeg_valid <= 1'b0;
			mpeg_sync <= 1'b0;
			mpeg_data <= 8'($urandom);
		end
		@(posedge mpeg_clk);
		mpeg_valid <= 1'b1;
		mpeg_sync <= s;
		mpeg_data <= b;
		hist_data.push_back(b);
		hist_sync.push_back(s);
		hist_rep.push_back(rep);
		hist_pos.push_back(pos);
	endtask

	task stream_idle();
		@(posedge mpeg_clk);
		mpeg_valid <= 1'b0;
		mpeg_sync <= 1'b0;
	endtask

	task send_packet(input tsp_pkg::pid_t p, input int len);
		tsp_pkg::ts_byte_t pkt [0:tsp_pkg::PKT_BYTES-1];
		logic rep;
		int i;
		rep = rep_en_m && (p == rep_pid_m);
		pkt[0] = tsp_pkg::SYNC_BYTE;
		pkt[1] = {3'($urandom), p[12:8]};
		pkt[2] = p[7:0];
		for (i = 3; i < tsp_pkg::PKT_BYTES; i++) begin
			pkt[i] = 8'($urandom);
		end
		// only a whole matching packet can be captured.
		if (len == tsp_pkg::PKT_BYTES && cap_pending && mon_en_m && p == mon_pid_m) begin
			for (i = 0; i < tsp_pkg::PKT_WORDS; i++) begin
				cap_q.push_back({pkt[4*i+3], pkt[4*i+2], pkt[4*i+1], pkt[4*i]});
			end
			cap_pending = 1'b0;
		end
		for (i = 0; i < len; i++) begin
			push_byte(pkt[i], i == 0, rep, i);
		end
	endtask

	task write_reg(input tsp_pkg::reg_addr_t a, input tsp_pkg::reg_data_t d);
		@(posedge mpeg_clk);
		wen <= 1'b1;
		waddr <= a;
		wdata <= d;
		@(posedge mpeg_clk);
		wen <= 1'b0;
	endtask

	task read_reg(input tsp_pkg::reg_addr_t a, output tsp_pkg::reg_data_t d);
		@(posedge mpeg_clk);
		ren <= 1'b1;
		raddr <= a;
		@(posedge mpeg_clk);
		ren <= 1'b0;
		@(negedge mpeg_clk);
		d = rdata;
	endtask

	task set_pid(input tsp_pkg::reg_addr_t a, input logic en, input tsp_pkg::pid_t p);
		tsp_pkg::reg_data_t rd;
		write_reg(a, pid_word(en, p));
		if (a == tsp_pkg::ADDR_MON_PID) begin
			mon_en_m = en;
			mon_pid_m = p;
		end else begin
			rep_en_m = en;
			rep_pid_m = p;
		end
		read_reg(a, rd);
		check_word("rdata", rd, pid_word(en, p));
	endtask

	task arm_capture();
		write_reg(tsp_pkg::ADDR_CAP_ARM, '0);
		cap_pending = 1'b1;
	endtask

	task check_capture();
		tsp_pkg::reg_data_t rd;
		int tries;
		int w;
		tries = 0;
		rd = '0;
		while (rd[0] !== 1'b1 && tries < 64) begin
			read_reg(tsp_pkg::ADDR_STATUS, rd);
			tries++;
		end
		if (rd[0] !== 1'b1) begin
			fail_now("capture ready never rose after the capture was armed");
		end
		if (cap_q.size() < tsp_pkg::PKT_WORDS) begin
			fail_now("capture ready rose but no matching packet was sent");
		end
		for (w = 0; w < tsp_pkg::PKT_WORDS; w++) begin
			read_reg(tsp_pkg::ADDR_PKT_BASE + tsp_pkg::reg_addr_t'(w), rd);
			check_word("rdata", rd, cap_q.pop_front());
		end
	endtask

	// everything but the three bytes held in the delay line must come out.
	task wait_drain();
		int t;
		t = 0;
		while (out_cnt != hist_data.size() - 3 && t < 50) begin
			@(posedge mpeg_clk);
			t++;
		end
		if (out_cnt != hist_data.size() - 3) begin
			fail_now("output stream stopped short of the last three input bytes");
		end
	endtask

	initial begin
		int i;
		void'($urandom(32'hba03));
		mpeg_clk = 1'b0;
		rst_n = 1'b0;
		mpeg_data = '0;
		mpeg_valid = 1'b0;
		mpeg_sync = 1'b0;
		wen = 1'b0;
		waddr = '0;
		wdata = '0;
		ren = 1'b0;
		raddr = '0;
		out_cnt = 0;
		in_cnt = 0;
		in_prev = 1'b0;
		mon_en_m = 1'b0;
		rep_en_m = 1'b0;
		mon_pid_m = '0;
		rep_pid_m = '0;
		cap_pending = 1'b0;
		pid_list[0] = 13'h0100;
		pid_list[1] = 13'h0a21;
		pid_list[2] = 13'h1ffe;
		repeat (4) @(posedge mpeg_clk);
		rst_n <= 1'b1;

		set_pid(tsp_pkg::ADDR_MON_PID, 1'b1, pid_list[0]);
		set_pid(tsp_pkg::ADDR_REP_PID, 1'b1, pid_list[1]);
		set_pid(tsp_pkg::ADDR_MON_PID, 1'b0, pid_list[0]);
		set_pid(tsp_pkg::ADDR_REP_PID, 1'b0, pid_list[1]);

		for (i = 0; i < 6; i++) begin
			send_packet(pid_list[$urandom_range(2, 0)], tsp_pkg::PKT_BYTES);
		end
		stream_idle();
		wait_drain();

		rep_pkt[0] = tsp_pkg::SYNC_BYTE;
		for (i = 1; i < tsp_pkg::PKT_BYTES; i++) begin
			rep_pkt[i] = 8'($urandom);
		end
		for (i = 0; i < tsp_pkg::PKT_WORDS; i++) begin
			write_reg(tsp_pkg::ADDR_PKT_BASE + tsp_pkg::reg_addr_t'(i),
				{rep_pkt[4*i+3], rep_pkt[4*i+2], rep_pkt[4*i+1], rep_pkt[4*i]});
		end
		set_pid(tsp_pkg::ADDR_REP_PID, 1'b1, pid_list[1]);
		for (i = 0; i < 8; i++) begin
			send_packet((i == 0) ? pid_list[1] : pid_list[$urandom_range(2, 0)],
				tsp_pkg::PKT_BYTES);
		end
		stream_idle();
		wait_drain();

		set_pid(tsp_pkg::ADDR_MON_PID, 1'b1, pid_list[0]);
		arm_capture();
		for (i = 0; i < 4; i++) begin
			send_packet((i == 3) ? pid_list[0] : pid_list[$urandom_range(2, 0)],
				tsp_pkg::PKT_BYTES);
		end
		stream_idle();
		check_capture();

		// the cut packet holds the monitor PID, so capture must skip to the next one.
		arm_capture();
		send_packet(pid_list[0], 100);
		send_packet(pid_list[1], tsp_pkg::PKT_BYTES);
		send_packet(pid_list[0], tsp_pkg::PKT_BYTES);
		stream_idle();
		check_capture();
		wait_drain();

		$display("RESULT: PASS");
		$finish;
	end

endmodule
